// ==== armPipeline.f ====
source/isaPkg.sv
source/pipePkg.sv
source/decodeStage.sv
source/registerFile.sv
source/hazardUnit.sv
source/executeStage.sv
source/memAccessStage.sv
source/armPipeline.sv
bench/armPipeline_asserts.sv
bench/armPipelineTb.sv

// ==== bench/armPipelineTb.sv ====
module armPipelineTb import isaPkg::*, pipePkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam word_t RESET_PC   = 32'h0000_0100;
   localparam int    N_RANDOM   = 80;
   localparam int    PROG_WORDS = N_RANDOM + 16;   // Random part, 15 stores, final loop
   localparam int    MEM_WORDS  = 128;
   localparam int    MAX_CYCLES = 8 * PROG_WORDS + 200;

   logic      clk;
   logic      reset;
   word_t     i_inst = '0;
   word_t     o_pc;
   storeReq_s o_store;

   word_t       imem [MEM_WORDS];
   storeReq_s   expStores [$];
   int unsigned lcgState = 4;
   int          cycles = 0;

   armPipeline #(.RESET_PC(RESET_PC)) u_armPipeline (
      .clk     (clk),
      .reset   (reset),
      .i_inst  (i_inst),
      .o_pc    (o_pc),
      .o_store (o_store)
   );

   function automatic int unsigned nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState >> 8;
   endfunction

   function automatic word_t fillWord(word_t addr);
      return addr ^ {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
   endfunction

   function automatic word_t encodeDp(instrClass_e cls, logic [3:0] cmd, logic imm,
                                      regIdx_t rd, regIdx_t rn, logic [11:0] op2);
      instrWord_u w;
      w             = '0;
      w.dp.cond     = 4'hE;   // Always
      w.dp.cls      = cls;
      w.dp.imm      = imm;
      w.dp.cmd      = cmd;
      w.dp.rn       = rn;
      w.dp.rd       = rd;
      w.dp.operand2 = op2;
      return w;
   endfunction

   function automatic word_t encodeBranch(logic link, logic [23:0] offset);
      instrWord_u w;
      w           = '0;
      w.br.cond   = 4'hE;
      w.br.cls    = BRANCH;
      w.br.link   = link;
      w.br.offset = offset;
      return w;
   endfunction

   task automatic buildProgram();
      aluCmd_e     cmds [5];
      regIdx_t     lastRd;
      regIdx_t     rn;
      int unsigned pick;
      int          skip;
      cmds   = '{AND, SUB, ADD, ORR, MOV};
      lastRd = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         imem[i] = fillWord(RESET_PC + 4 * i);
      end
      for (int i = 0; i < N_RANDOM; i++) begin
         pick = nextRand() % 16;
         rn   = (nextRand() % 4 == 0) ? lastRd : regIdx_t'(nextRand() % 16);   // Dependencies
         if (pick < 10) begin
            lastRd  = regIdx_t'(nextRand() % 15);
            imem[i] = encodeDp(DATA, cmds[nextRand() % 5], 1'(nextRand()), lastRd, rn,
                               12'(nextRand()));
         end else if (pick < 13) begin
            imem[i] = encodeDp(MEM, 4'b1000, 1'b1, regIdx_t'(nextRand() % 16), rn,
                               12'(nextRand()));
         end else begin
            skip = int'(nextRand() % 4);
            if (skip > N_RANDOM - 1 - i) begin
               skip = N_RANDOM - 1 - i;   // Lands no later than the first final store
            end
            imem[i] = encodeBranch(pick == 15, 24'(skip));
         end
      end
      for (int k = 0; k < 15; k++) begin
         imem[N_RANDOM + k] = encodeDp(MEM, 4'b1000, 1'b1, regIdx_t'(k), PC_REG, 12'h400);
      end
      imem[PROG_WORDS - 1] = encodeBranch(1'b0, 24'hFF_FFFF);   // Back onto itself
   endtask

   // Sequential ISA model filling the expected store list
   task automatic runModel();
      word_t      regs [16];
      word_t      pc;
      word_t      opB;
      word_t      result;
      instrWord_u w;
      regs = '{default: '0};
      pc   = RESET_PC;
      while ((pc - RESET_PC) / 4 != PROG_WORDS - 1) begin
         w        = imem[(pc - RESET_PC) / 4];
         regs[15] = pc + 4;
         case (w.dp.cls)
            DATA: begin
               opB = w.dp.imm ? {20'd0, w.dp.operand2}
                              : regs[w.dp.operand2[3:0]] << w.dp.operand2[11:7];
               case (w.dp.cmd)
                  AND:     result = regs[w.dp.rn] & opB;
                  SUB:     result = regs[w.dp.rn] - opB;
                  ADD:     result = regs[w.dp.rn] + opB;
                  ORR:     result = regs[w.dp.rn] | opB;
                  default: result = opB;   // MOV
               endcase
               regs[w.dp.rd] = result;
               pc            = pc + 4;
            end
            MEM: begin
               expStores.push_back('{strobe: 1'b1,
                                     addr: regs[w.dp.rn] + {20'd0, w.dp.operand2},
                                     data: regs[w.dp.rd]});
               pc = pc + 4;
            end
            default: begin
               if (w.br.link) begin
                  regs[LINK_REG] = pc + 4;
               end
               pc = pc + 4 + {{6{w.br.offset[23]}}, w.br.offset, 2'b00};
            end
         endcase
      end
   endtask

   task automatic stopRun();
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped on a failed check");
   endtask

   task automatic checkStore(storeReq_s got, storeReq_s exp);
      if (got !== exp) begin
         $display("Error at %0d ns: o_store got %b/%h/%h, expected %b/%h/%h", $time,
                  got.strobe, got.addr, got.data, exp.strobe, exp.addr, exp.data);
         stopRun();
      end
   endtask

   task automatic checkPc(word_t got, word_t exp);
      if (got !== exp) begin
         $display("Error at %0d ns: o_pc got %h, expected %h", $time, got, exp);
         stopRun();
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Instruction memory follows o_pc
   always @(o_pc) begin
      if ((o_pc - RESET_PC) / 4 < MEM_WORDS) begin
         i_inst <= imem[(o_pc - RESET_PC) / 4];
      end else begin
         i_inst <= fillWord(o_pc);
      end
   end

   always @(negedge clk) begin
      if (reset) begin
         if (o_store.strobe === 1'b1) begin
            $display("Store strobe raised while reset was held");
            stopRun();
         end
      end else if (o_store.strobe !== 1'b0) begin
         if (expStores.size() == 0) begin
            $display("Extra store at %0d ns to address %h", $time, o_store.addr);
            stopRun();
         end else begin
            checkStore(o_store, expStores.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("Timeout after %0d cycles with %0d stores still missing", cycles,
                  expStores.size());
         stopRun();
      end
   end

   initial begin
      buildProgram();
      runModel();
      reset = 1'b1;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      checkPc(o_pc, RESET_PC);
      while (expStores.size() != 0) begin
         @(negedge clk);
      end
      repeat (50) @(negedge clk);   // Final loop stays quiet
      if (u_armPipeline.u_armPipelineAsserts.failCount == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         $display("Bound assertions failed %0d times",
                  u_armPipeline.u_armPipelineAsserts.failCount);
         stopRun();
      end
   end

endmodule

// ==== bench/armPipeline_asserts.sv ====
module armPipelineAsserts import isaPkg::*, pipePkg::*; (
   input logic      clk,
   input logic      reset,
   input word_t     i_pc,
   input storeReq_s i_store
);
   timeunit 1ns;
   timeprecision 100ps;

   int failCount = 0;

   // EX/MEM is cleared by reset
   strobeQuietInReset: assert property (@(posedge clk) reset |-> i_store.strobe !== 1'b1)
      else begin
         $error("store strobe high during reset");
         failCount++;
      end

   pcAligned: assert property (@(posedge clk) disable iff (reset) i_pc[1:0] == 2'b00)
      else begin
         $error("o_pc not word aligned: %h", i_pc);
         failCount++;
      end

   storeKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(i_store))
      else begin
         $error("o_store has unknown bits");
         failCount++;
      end

endmodule

bind armPipeline armPipelineAsserts u_armPipelineAsserts (
   .clk     (clk),
   .reset   (reset),
   .i_pc    (o_pc),
   .i_store (o_store)
);

// ==== source/armPipeline.sv ====
module armPipeline import isaPkg::*, pipePkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic      clk,
   input  logic      reset,
   input  word_t     i_inst,
   output word_t     o_pc,
   output storeReq_s o_store
);

   regIdx_t src1;
   regIdx_t src2;
   word_t   read1;
   word_t   read2;
   word_t   target;
   logic    validD;
   logic    isBranchD;
   logic    isLinkD;
   logic    stall;
   logic    squash;
   logic    linkWrite;
   logic    branchTaken;
   idEx_s   idExD;
   idEx_s   idExE;
   exMem_s  exMemE;
   exMem_s  exMemM;
   wb_s     wb;

   decodeStage u_decodeStage (
      .clk        (clk),
      .reset      (reset),
      .i_inst     (i_inst),
      .i_stall    (stall),
      .i_squash   (squash),
      .i_read1    (read1),
      .i_read2    (read2),
      .o_src1     (src1),
      .o_src2     (src2),
      .o_valid    (validD),
      .o_isBranch (isBranchD),
      .o_isLink   (isLinkD),
      .o_idEx     (idExD)
   );

   registerFile #(.RESET_PC(RESET_PC)) u_registerFile (
      .clk           (clk),
      .reset         (reset),
      .i_src1        (src1),
      .i_src2        (src2),
      .i_wb          (wb),
      .i_linkWrite   (linkWrite),
      .i_stall       (stall),
      .i_branchTaken (branchTaken),
      .i_target      (target),
      .o_read1       (read1),
      .o_read2       (read2),
      .o_pc          (o_pc)
   );

   hazardUnit u_hazardUnit (
      .clk         (clk),
      .reset       (reset),
      .i_valid     (validD),
      .i_src1      (src1),
      .i_src2      (src2),
      .i_isBranch  (isBranchD),
      .i_isLink    (isLinkD),
      .i_idEx      (idExE),
      .i_exMem     (exMemM),
      .i_wb        (wb),
      .o_stall     (stall),
      .o_squash    (squash),
      .o_linkWrite (linkWrite)
   );

   executeStage u_executeStage (
      .clk           (clk),
      .reset         (reset),
      .i_idEx        (idExD),
      .i_bubble      (stall),   // Stalled D leaves a hole in E
      .o_idExQ       (idExE),
      .o_exMem       (exMemE),
      .o_branchTaken (branchTaken),
      .o_target      (target)
   );

   memAccessStage u_memAccessStage (
      .clk      (clk),
      .reset    (reset),
      .i_exMem  (exMemE),
      .o_exMemQ (exMemM),
      .o_wb     (wb),
      .o_store  (o_store)
   );

endmodule

// ==== source/decodeStage.sv ====
module decodeStage import isaPkg::*, pipePkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  word_t   i_inst,
   input  logic    i_stall,
   input  logic    i_squash,
   input  word_t   i_read1,
   input  word_t   i_read2,
   output regIdx_t o_src1,
   output regIdx_t o_src2,
   output logic    o_valid,
   output logic    o_isBranch,
   output logic    o_isLink,
   output idEx_s   o_idEx
);

   instrWord_u instQ;
   logic       validQ;
   ctrl_s      ctrl;
   word_t      imm;

   // IF/ID register, squash beats stall
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         validQ <= 1'b0;
         instQ  <= '0;
      end else if (i_squash || !i_stall) begin
         validQ <= !i_squash;
         instQ  <= i_inst;
      end
   end

   always_comb begin
      ctrl   = '0;
      imm    = {20'd0, instQ.dp.operand2};
      o_src1 = instQ.dp.rn;
      o_src2 = instQ.dp.operand2[3:0];   // rm
      case (instQ.dp.cls)
         DATA: begin
            ctrl.regWrite = (instQ.dp.rd != PC_REG);
            ctrl.useImm   = instQ.dp.imm;
            ctrl.zeroA    = (instQ.dp.cmd == MOV);
            ctrl.aluCmd   = aluCmd_e'(instQ.dp.cmd);
         end
         MEM: begin
            ctrl.memWrite = instQ.dp.cmd[3];
            ctrl.useImm   = 1'b1;
            ctrl.aluCmd   = ADD;
            o_src2        = instQ.dp.rd;     // Store data
         end
         BRANCH: begin
            ctrl.isBranch = 1'b1;
            ctrl.isLink   = instQ.br.link;
            ctrl.useImm   = 1'b1;
            ctrl.aluCmd   = ADD;
            imm           = {{6{instQ.br.offset[23]}}, instQ.br.offset, 2'b00};
            o_src1        = PC_REG;
            o_src2        = PC_REG;
         end
         default: begin
            ctrl = '0;
         end
      endcase
      // Invalid slot issues nothing
      if (!validQ) begin
         ctrl = '0;
      end
   end

   assign o_valid    = validQ;
   assign o_isBranch = ctrl.isBranch;
   assign o_isLink   = ctrl.isLink;

   always_comb begin
      o_idEx.valid = validQ;
      o_idEx.ctrl  = ctrl;
      o_idEx.read1 = i_read1;
      o_idEx.read2 = i_read2;
      o_idEx.imm   = imm;
      o_idEx.shamt = instQ.dp.imm ? 5'd0 : instQ.dp.operand2[11:7];
      o_idEx.dest  = instQ.dp.rd;
   end

endmodule

// ==== source/executeStage.sv ====
module executeStage import isaPkg::*, pipePkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  idEx_s  i_idEx,
   input  logic   i_bubble,
   output idEx_s  o_idExQ,
   output exMem_s o_exMem,
   output logic   o_branchTaken,
   output word_t  o_target
);

   idEx_s idExQ;
   word_t opA;
   word_t opB;
   word_t result;

   // ID/EX register
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         idExQ <= '0;
      end else if (i_bubble) begin
         idExQ <= '0;
      end else begin
         idExQ <= i_idEx;
      end
   end

   assign opA = idExQ.ctrl.zeroA ? '0 : idExQ.read1;
   assign opB = idExQ.ctrl.useImm ? idExQ.imm : (idExQ.read2 << idExQ.shamt);

   always_comb begin
      case (idExQ.ctrl.aluCmd)
         AND:      result = opA & opB;
         SUB:      result = opA - opB;
         ADD:      result = opA + opB;
         ORR, MOV: result = opA | opB;   // MOV sees A as zero
         default:  result = '0;
      endcase
   end

   always_comb begin
      o_exMem.regWrite  = idExQ.ctrl.regWrite;
      o_exMem.memWrite  = idExQ.ctrl.memWrite;
      o_exMem.result    = result;
      o_exMem.storeData = idExQ.read2;
      o_exMem.dest      = idExQ.dest;
   end

   // Branches are unconditional
   assign o_branchTaken = idExQ.valid && idExQ.ctrl.isBranch;
   assign o_target      = result;   // R15 plus offset
   assign o_idExQ       = idExQ;

endmodule

// ==== source/hazardUnit.sv ====
module hazardUnit import isaPkg::*, pipePkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    i_valid,
   input  regIdx_t i_src1,
   input  regIdx_t i_src2,
   input  logic    i_isBranch,
   input  logic    i_isLink,
   input  idEx_s   i_idEx,
   input  exMem_s  i_exMem,
   input  wb_s     i_wb,
   output logic    o_stall,
   output logic    o_squash,
   output logic    o_linkWrite
);

   logic pending;   // Second wrong-path slot
   logic branchD;

   // Register still to be written by E, M or W
   function automatic logic inFlight(regIdx_t src);
      return (i_idEx.ctrl.regWrite && i_idEx.dest == src) ||
             (i_exMem.regWrite && i_exMem.dest == src) ||
             (i_wb.we && i_wb.dest == src);
   endfunction

   always_comb begin
      o_stall = i_valid && (inFlight(i_src1) || inFlight(i_src2) ||
                            (i_isLink && inFlight(LINK_REG)));
   end

   assign branchD     = i_valid && i_isBranch && !o_stall;
   assign o_squash    = branchD || pending;
   assign o_linkWrite = i_valid && i_isLink && !o_stall;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pending <= 1'b0;
      end else begin
         pending <= branchD;
      end
   end

endmodule

// ==== source/isaPkg.sv ====
package isaPkg;

   typedef logic [31:0] word_t;
   typedef logic [3:0]  regIdx_t;

   localparam regIdx_t LINK_REG = 4'd14;
   localparam regIdx_t PC_REG   = 4'd15;

   typedef enum logic [1:0] {
      DATA   = 2'b00,
      MEM    = 2'b01,
      BRANCH = 2'b10
   } instrClass_e;

   typedef enum logic [3:0] {
      AND = 4'b0000,
      SUB = 4'b0010,
      ADD = 4'b0100,
      ORR = 4'b1100,
      MOV = 4'b1101
   } aluCmd_e;

   // Data processing and store layout
   typedef struct packed {
      logic [3:0]  cond;      // Not evaluated
      instrClass_e cls;
      logic        imm;
      logic [3:0]  cmd;       // MEM class: bit 24 set is a store
      logic        setFlags;  // Not evaluated
      regIdx_t     rn;
      regIdx_t     rd;
      logic [11:0] operand2;  // Shift form uses 11:7 and 3:0
   } dpFormat_s;

   typedef struct packed {
      logic [3:0]  cond;
      instrClass_e cls;
      logic        unused;
      logic        link;
      logic [23:0] offset;    // Signed word offset
   } brFormat_s;

   typedef union packed {
      dpFormat_s dp;
      brFormat_s br;
   } instrWord_u;

endpackage

// ==== source/memAccessStage.sv ====
module memAccessStage import pipePkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  exMem_s    i_exMem,
   output exMem_s    o_exMemQ,
   output wb_s       o_wb,
   output storeReq_s o_store
);

   exMem_s exMemQ;
   wb_s    wbQ;

   // EX/MEM then MEM/WB
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         exMemQ <= '0;
         wbQ    <= '0;
      end else begin
         exMemQ   <= i_exMem;
         wbQ.we   <= exMemQ.regWrite;
         wbQ.dest <= exMemQ.dest;
         wbQ.data <= exMemQ.result;
      end
   end

   assign o_store = '{strobe: exMemQ.memWrite, addr: exMemQ.result, data: exMemQ.storeData};

   assign o_exMemQ = exMemQ;
   assign o_wb     = wbQ;

endmodule

// ==== source/pipePkg.sv ====
package pipePkg;
   import isaPkg::*;

   // Decoded control, all zero for a bubble
   typedef struct packed {
      logic    regWrite;
      logic    memWrite;
      logic    isBranch;
      logic    isLink;
      logic    useImm;    // Operand B from immediate
      logic    zeroA;     // Operand A forced to zero
      aluCmd_e aluCmd;
   } ctrl_s;

   typedef struct packed {
      logic       valid;
      ctrl_s      ctrl;
      word_t      read1;
      word_t      read2;
      word_t      imm;
      logic [4:0] shamt;
      regIdx_t    dest;
   } idEx_s;

   typedef struct packed {
      logic    regWrite;
      logic    memWrite;
      word_t   result;
      word_t   storeData;
      regIdx_t dest;
   } exMem_s;

   typedef struct packed {
      logic    we;
      regIdx_t dest;
      word_t   data;
   } wb_s;

   // Store port of the core
   typedef struct packed {
      logic  strobe;
      word_t addr;
      word_t data;
   } storeReq_s;

endpackage

// ==== source/registerFile.sv ====
module registerFile import isaPkg::*, pipePkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic    clk,
   input  logic    reset,
   input  regIdx_t i_src1,
   input  regIdx_t i_src2,
   input  wb_s     i_wb,
   input  logic    i_linkWrite,
   input  logic    i_stall,
   input  logic    i_branchTaken,
   input  word_t   i_target,
   output word_t   o_read1,
   output word_t   o_read2,
   output word_t   o_pc
);

   word_t regs [0:14];
   word_t pc;          // R15

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 15; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (i_wb.we && i_wb.dest != PC_REG) begin
            regs[i_wb.dest] <= i_wb.data;
         end
         // BL return address, later assignment wins
         if (i_linkWrite) begin
            regs[LINK_REG] <= pc;
         end
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pc <= RESET_PC;
      end else if (i_branchTaken) begin
         pc <= i_target;
      end else if (!i_stall) begin
         pc <= pc + 32'd4;
      end
   end

   assign o_read1 = (i_src1 == PC_REG) ? pc : regs[i_src1];
   assign o_read2 = (i_src2 == PC_REG) ? pc : regs[i_src2];
   assign o_pc    = pc;

endmodule
